//--- sources.f
+incdir+design
+incdir+tests
design/fpnorm_pkg.sv
design/fpnorm_special.sv
design/fpnorm_shift.sv
design/fpnorm_round.sv
design/fpnorm_pack.sv
design/fpnorm_top.sv
tests/tb_fpnorm.sv

//--- Bender.yml
package:
  name: fpnorm

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/fpnorm_pkg.sv
      - design/fpnorm_special.sv
      - design/fpnorm_shift.sv
      - design/fpnorm_round.sv
      - design/fpnorm_pack.sv
      - design/fpnorm_top.sv
  - target: test
    include_dirs:
      - design
      - tests
    files:
      - tests/tb_fpnorm.sv

//--- tests/fpnorm_vectors.svh
////////////////////
// Vector table for the normalize and round stage
// Columns are name, mant_in, exp_in, {sign, op_sqrt, fp64}, rm, op_class,
// expected result and {nv, dz, of, uf, nx}
////////////////////

`ifndef FPNORM_VECTORS_SVH
`define FPNORM_VECTORS_SVH

task automatic load_vectors;
  begin
    ////////////////////
    // FP64 rounding of 1.0...01 with guard and sticky set
    add_vector("rne_up", 57'h1_0000000000001_a, 13'd1023, 3'b001, rne, 7'b0000000,
               64'h3ff0_0000_0000_0002, 5'b00001);
    add_vector("rtz", 57'h1_0000000000001_a, 13'd1023, 3'b001, rtz, 7'b0000000,
               64'h3ff0_0000_0000_0001, 5'b00001);
    add_vector("rup_pos", 57'h1_0000000000001_a, 13'd1023, 3'b001, rup, 7'b0000000,
               64'h3ff0_0000_0000_0002, 5'b00001);
    add_vector("rdn_neg", 57'h1_0000000000001_a, 13'd1023, 3'b101, rdn, 7'b0000000,
               64'hbff0_0000_0000_0002, 5'b00001);
    add_vector("rup_neg", 57'h1_0000000000001_a, 13'd1023, 3'b101, rup, 7'b0000000,
               64'hbff0_0000_0000_0001, 5'b00001);
    // Exact ties where even LSB stays and odd LSB rounds up
    add_vector("rne_tie_even", 57'h1_0000000000002_8, 13'd1023, 3'b001, rne, 7'b0000000,
               64'h3ff0_0000_0000_0002, 5'b00001);
    add_vector("rne_tie_odd", 57'h1_0000000000003_8, 13'd1023, 3'b001, rne, 7'b0000000,
               64'h3ff0_0000_0000_0004, 5'b00001);
    add_vector("rne_carry", 57'h1_fffffffffffff_c, 13'd1023, 3'b001, rne, 7'b0000000,
               64'h4000_0000_0000_0000, 5'b00001);   // 2.0 after carry
    add_vector("exact", 57'h1_8000000000000_0, 13'd1024, 3'b001, rne, 7'b0000000,
               64'h4008_0000_0000_0000, 5'b00000);
    add_vector("norm_0p1x", 57'h0_c000000000000_8, 13'd1024, 3'b001, rne, 7'b0000000,
               64'h3ff8_0000_0000_0001, 5'b00000);   // Exponent drops by one

    ////////////////////
    // FP32 boxed and rounded at fraction bit 23
    add_vector("fp32_rne", 57'h1_0000030000000_0, 13'd127, 3'b000, rne, 7'b0000000,
               64'hffff_ffff_3f80_0002, 5'b00001);
    add_vector("fp32_rtz", 57'h1_0000030000000_0, 13'd127, 3'b000, rtz, 7'b0000000,
               64'hffff_ffff_3f80_0001, 5'b00001);
    add_vector("fp32_carry", 57'h1_fffffffffffff_0, 13'd127, 3'b000, rne, 7'b0000000,
               64'hffff_ffff_4000_0000, 5'b00001);

    ////////////////////
    // Denormals and overflow
    add_vector("denorm_neg", 57'h1_0000000000000_0, 13'h1fff, 3'b001, rne, 7'b0000000,
               64'h0004_0000_0000_0000, 5'b00010);   // Exponent -1
    add_vector("denorm_round", 57'h1_0000000000002_0, 13'h1fff, 3'b001, rup, 7'b0000000,
               64'h0004_0000_0000_0001, 5'b00011);
    add_vector("denorm_shift4", 57'h1_0000000000000_0, 13'h1ffd, 3'b001, rne, 7'b0000000,
               64'h0001_0000_0000_0000, 5'b00010);   // Exponent -3
    add_vector("denorm_exp0", 57'h1_0000000000000_0, 13'd0, 3'b001, rne, 7'b0000000,
               64'h0008_0000_0000_0000, 5'b00010);
    add_vector("ovf_fp64", 57'h1_0000000000000_0, 13'd2048, 3'b001, rne, 7'b0000000,
               64'h7ff0_0000_0000_0000, 5'b00100);
    add_vector("ovf_ones_neg", 57'h1_0000000000000_0, 13'd2047, 3'b101, rne, 7'b0000000,
               64'hfff0_0000_0000_0000, 5'b00100);
    add_vector("ovf_fp32", 57'h1_0000000000000_0, 13'd255, 3'b000, rne, 7'b0000000,
               64'hffff_ffff_7f80_0000, 5'b00100);

    ////////////////////
    // Special operands with class bits nan_a nan_b inf_a inf_b zero_a zero_b snan
    add_vector("qnan_a", 57'h0, 13'd0, 3'b001, rne, 7'b1000000,
               64'h7ff8_0000_0000_0000, 5'b00000);
    add_vector("snan_b", 57'h0, 13'd0, 3'b001, rne, 7'b0100001,
               64'h7ff8_0000_0000_0000, 5'b10000);
    add_vector("nan_fp32", 57'h0, 13'd0, 3'b000, rne, 7'b1000000,
               64'hffff_ffff_7fc0_0000, 5'b00000);
    add_vector("inf_div_inf", 57'h0, 13'd0, 3'b101, rne, 7'b0011000,
               64'h7ff8_0000_0000_0000, 5'b10000);
    add_vector("zero_div_zero", 57'h0, 13'd0, 3'b001, rne, 7'b0000110,
               64'h7ff8_0000_0000_0000, 5'b10000);
    add_vector("sqrt_neg_inf", 57'h0, 13'd0, 3'b111, rne, 7'b0010000,
               64'h7ff8_0000_0000_0000, 5'b10000);
    add_vector("inf_a_neg", 57'h0, 13'd0, 3'b101, rne, 7'b0010000,
               64'hfff0_0000_0000_0000, 5'b00100);
    add_vector("div_by_inf", 57'h0, 13'd0, 3'b101, rne, 7'b0001000,
               64'h8000_0000_0000_0000, 5'b00100);
    // Datapath carries 1.0 so only the forced zero gives this result
    add_vector("zero_a_neg", 57'h1_0000000000000_0, 13'd1023, 3'b101, rne, 7'b0000100,
               64'h8000_0000_0000_0000, 5'b00000);
    add_vector("div_by_zero", 57'h0, 13'd0, 3'b001, rne, 7'b0000010,
               64'h7ff0_0000_0000_0000, 5'b01000);
    add_vector("sqrt_neg", 57'h1_0000000000000_0, 13'd1023, 3'b111, rne, 7'b0000000,
               64'h7ff8_0000_0000_0000, 5'b10000);
  end
endtask

`endif

//--- tests/tb_fpnorm.sv
////////////////////
// Testbench for the normalize and round stage
// Applies the vector table, checks result, flags and valid timing
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "fpnorm_cfg.svh"

module tb_fpnorm;

  import fpnorm_pkg::*;

  localparam rm_t rne = `FPN_RM_NEAREST;
  localparam rm_t rtz = `FPN_RM_TRUNC;
  localparam rm_t rup = `FPN_RM_PLUSINF;
  localparam rm_t rdn = `FPN_RM_MINUSINF;

  // One table row
  typedef struct packed {
    mant_ext_t      mant;
    exp_ext_t       exponent;
    logic [2:0]     ctrl;       // sign, op_sqrt, fp64
    rm_t            rm;
    operand_class_t op_class;
    result_t        result;     // Expected
    fflags_t        fflags;     // Expected
  } vector_t;

  logic           clk;
  logic           rst_n;
  logic           in_valid;
  mant_ext_t      mant_in;
  exp_ext_t       exp_in;
  logic           sign_in;
  logic           op_sqrt;
  logic           fp64;
  rm_t            rm;
  operand_class_t op_class;
  result_t        result;
  fflags_t        fflags;
  logic           out_valid;

  vector_t vectors [$];
  string   names [$];
  vector_t cur;
  int      errors;
  int      checks;
  int      wait_cycles;
  int      limit;

  fpnorm_top dut (.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .mant_in(mant_in),
                  .exp_in(exp_in), .sign_in(sign_in), .op_sqrt(op_sqrt), .fp64(fp64),
                  .rm(rm), .op_class(op_class), .result(result), .fflags(fflags),
                  .out_valid(out_valid));

  always #4 clk = ~clk;   // 8 ns period

  task automatic add_vector(input string name, input mant_ext_t mant, input exp_ext_t exponent,
                            input logic [2:0] ctrl, input rm_t mode,
                            input operand_class_t cls, input result_t res,
                            input fflags_t flags);
    vector_t v;
    begin
      v.mant     = mant;
      v.exponent = exponent;
      v.ctrl     = ctrl;
      v.rm       = mode;
      v.op_class = cls;
      v.result   = res;
      v.fflags   = flags;
      vectors.push_back(v);
      names.push_back(name);
    end
  endtask

  `include "fpnorm_vectors.svh"

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    begin
      checks++;
      if (actual !== expected)
      begin
        errors++;
        $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      end
    end
  endtask

  ////////////////////
  // Stimulus and checks
  initial
  begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    mant_in  = '0;
    exp_in   = '0;
    sign_in  = 1'b0;
    op_sqrt  = 1'b0;
    fp64     = 1'b0;
    rm       = '0;
    op_class = '0;
    errors   = 0;
    checks   = 0;
    load_vectors();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("reset out_valid", 64'd0, out_valid);   // Idle after reset
    check_value("reset result", 64'd0, result);
    check_value("reset fflags", 64'd0, fflags);
    for (int i = 0; i < vectors.size(); i++)
    begin
      @(posedge clk);
      cur = vectors[i];
      mant_in  <= cur.mant;
      exp_in   <= cur.exponent;
      sign_in  <= cur.ctrl[2];
      op_sqrt  <= cur.ctrl[1];
      fp64     <= cur.ctrl[0];
      rm       <= cur.rm;
      op_class <= cur.op_class;
      in_valid <= 1'b1;
      @(posedge clk);   // DUT captures here
      in_valid <= 1'b0;
      wait_cycles = 0;
      @(negedge clk);
      while (!out_valid && wait_cycles < 10)
      begin
        wait_cycles++;
        @(negedge clk);
      end
      if (!out_valid)
      begin
        errors++;
        $display("%s: out_valid never went high after in_valid", names[i]);
      end
      else
      begin
        check_value({names[i], " latency"}, 64'd0, wait_cycles);   // Exactly one cycle
        check_value({names[i], " result"}, cur.result, result);
        check_value({names[i], " fflags"}, cur.fflags, fflags);
        @(negedge clk);
        check_value({names[i], " pulse"}, 64'd0, out_valid);   // Single cycle
      end
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  ////////////////////
  // Watchdog, about 3 cycles per row needed
  initial
  begin
    #1;
    limit = vectors.size() * 4 + 100;
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- design/fpnorm_top.sv
////////////////////
// Normalize and round stage top
// Divide/sqrt back end with one output register
////////////////////

`timescale 1ns/100ps
`default_nettype none

module fpnorm_top
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       in_valid,   // One-cycle pulse
  input  fpnorm_pkg::mant_ext_t      mant_in,
  input  fpnorm_pkg::exp_ext_t       exp_in,
  input  logic                       sign_in,
  input  logic                       op_sqrt,    // 1 sqrt, 0 divide
  input  logic                       fp64,       // 1 FP64, 0 FP32
  input  fpnorm_pkg::rm_t            rm,
  input  fpnorm_pkg::operand_class_t op_class,
  output fpnorm_pkg::result_t        result,
  output fpnorm_pkg::fflags_t        fflags,
  output logic                       out_valid
);

  import fpnorm_pkg::*;

  special_word_t special_w;
  norm_word_t    norm_w;
  mant_norm_t    mant_rnd;
  exp_t          exp_rnd;
  logic          sign_rnd;
  logic          of_rnd;
  logic          uf_rnd;
  logic          nx;

  fpnorm_special u_special (.op_class(op_class), .sign_in(sign_in), .op_sqrt(op_sqrt),
                            .special(special_w));

  fpnorm_shift u_shift (.mant_in(mant_in), .exp_in(exp_in), .sign_in(sign_in), .fp64(fp64),
                        .norm(norm_w));

  fpnorm_round u_round (.norm(norm_w), .fp64(fp64), .rm(rm), .mant_rnd(mant_rnd),
                        .exp_rnd(exp_rnd), .sign_rnd(sign_rnd), .of_rnd(of_rnd),
                        .uf_rnd(uf_rnd), .nx(nx));

  // Registered output stage
  fpnorm_pack u_pack (.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .fp64(fp64),
                      .special(special_w), .mant_rnd(mant_rnd), .exp_rnd(exp_rnd),
                      .sign_rnd(sign_rnd), .of_rnd(of_rnd), .uf_rnd(uf_rnd), .nx(nx),
                      .result(result), .fflags(fflags), .out_valid(out_valid));

endmodule

`default_nettype wire

//--- design/fpnorm_pack.sv
////////////////////
// Result packer
// Selects special or rounded value, boxes FP32, output register
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "fpnorm_cfg.svh"

module fpnorm_pack
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_valid,
  input  logic                      fp64,
  input  fpnorm_pkg::special_word_t special,
  input  fpnorm_pkg::mant_norm_t    mant_rnd,
  input  fpnorm_pkg::exp_t          exp_rnd,
  input  logic                      sign_rnd,
  input  logic                      of_rnd,
  input  logic                      uf_rnd,
  input  logic                      nx,
  output fpnorm_pkg::result_t       result,
  output fpnorm_pkg::fflags_t       fflags,
  output logic                      out_valid
);

  import fpnorm_pkg::*;

  logic                      sign_sel;
  exp_t                      exp_sel;
  logic [`FPN_MANT_FP64-1:0] frac_sel;   // Hidden bit dropped
  result_t                   result_next;
  fflags_t                   fflags_next;

  always_comb
  begin
    fflags_next = '0;
    if (special.hit)   // Forced value, never inexact
    begin
      sign_sel       = special.sign;
      exp_sel        = {`FPN_EXP_FP64{special.exp_ones}};
      frac_sel       = special.mant_nan ? `FPN_MANT_NAN_FP64 : {`FPN_MANT_FP64{1'b0}};
      fflags_next.nv = special.nv;
      fflags_next.dz = special.dz;
      fflags_next.of = special.of;
    end
    else
    begin
      sign_sel       = sign_rnd;
      exp_sel        = exp_rnd;
      frac_sel       = mant_rnd[`FPN_MANT_FP64-1:0];
      fflags_next.of = of_rnd;
      fflags_next.uf = uf_rnd;
      fflags_next.nx = nx;
    end
  end

  // FP32 is NaN boxed in the upper word
  assign result_next = fp64 ? {sign_sel, exp_sel, frac_sel}
                            : {32'hffff_ffff, sign_sel, exp_sel[`FPN_EXP_FP32-1:0],
                               frac_sel[`FPN_MANT_FP64-1:`FPN_MANT_FP64-`FPN_MANT_FP32]};

  ////////////////////
  // Output register, one cycle latency
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      result    <= '0;
      fflags    <= '0;
      out_valid <= 1'b0;
    end
    else
    begin
      out_valid <= in_valid;   // Single-cycle pulse, no hold
      if (in_valid)
      begin
        result <= result_next;
        fflags <= fflags_next;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/fpnorm_round.sv
////////////////////
// Rounding unit
// Applies the rounding mode at the format LSB and renormalizes
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "fpnorm_cfg.svh"

module fpnorm_round
(
  input  fpnorm_pkg::norm_word_t norm,
  input  logic                   fp64,
  input  fpnorm_pkg::rm_t        rm,
  output fpnorm_pkg::mant_norm_t mant_rnd,
  output fpnorm_pkg::exp_t       exp_rnd,
  output logic                   sign_rnd,
  output logic                   of_rnd,
  output logic                   uf_rnd,
  output logic                   nx
);

  import fpnorm_pkg::*;

  mant_norm_t                upper;    // Kept bits of the format
  mant_norm_t                inc;      // One at the format LSB
  logic [1:0]                lower;    // Guard pair
  logic                      sticky;
  logic                      lsb;
  logic                      round_up;
  logic [`FPN_MANT_FP64+1:0] sum;
  logic                      renorm;

  ////////////////////
  // Guard and sticky select
  always_comb
  begin
    if (fp64)
    begin
      upper  = norm.mant;
      lower  = norm.tail[`FPN_MANT_FP64+4:`FPN_MANT_FP64+3];
      sticky = |norm.tail[`FPN_MANT_FP64+2:0];
      lsb    = norm.mant[0];
      inc    = 53'd1;
    end
    else   // FP32 rounds at fraction bit 23
    begin
      upper  = {norm.mant[`FPN_MANT_FP64:`FPN_MANT_FP64-`FPN_MANT_FP32],
                {(`FPN_MANT_FP64-`FPN_MANT_FP32){1'b0}}};
      lower  = norm.mant[`FPN_MANT_FP64-`FPN_MANT_FP32-1:`FPN_MANT_FP64-`FPN_MANT_FP32-2];
      sticky = |norm.mant[`FPN_MANT_FP64-`FPN_MANT_FP32-3:0];
      lsb    = norm.mant[`FPN_MANT_FP64-`FPN_MANT_FP32];
      inc    = 53'd1 << (`FPN_MANT_FP64 - `FPN_MANT_FP32);
    end
  end

  assign nx = |lower | sticky;   // Any discarded bit

  always_comb
  begin
    case (rm)
      `FPN_RM_NEAREST:  round_up = lower[1] && (lower[0] || sticky || lsb);
      `FPN_RM_TRUNC:    round_up = 1'b0;
      `FPN_RM_PLUSINF:  round_up = nx && !norm.sign;
      `FPN_RM_MINUSINF: round_up = nx && norm.sign;
      default:          round_up = 1'b0;
    endcase
  end

  ////////////////////
  // Increment and renormalize
  assign sum    = {1'b0, upper} + (round_up ? {1'b0, inc} : '0);
  assign renorm = sum[`FPN_MANT_FP64+1];   // Carry out of the hidden bit

  assign mant_rnd = renorm ? sum[`FPN_MANT_FP64+1:1] : sum[`FPN_MANT_FP64:0];

  // Carry bumps the exponent, a denormal rounding into 1.0 does too
  assign exp_rnd = (renorm || (norm.exp == '0 && sum[`FPN_MANT_FP64])) ? norm.exp + 1'b1
                                                                       : norm.exp;

  assign sign_rnd = norm.sign;
  assign of_rnd   = norm.of;
  assign uf_rnd   = norm.uf;

endmodule

`default_nettype wire

//--- design/fpnorm_shift.sv
////////////////////
// Mantissa normalizer
// Aligns 1.x and 0.1x values, builds denormals by right shift
// and flags exponent overflow and underflow
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "fpnorm_cfg.svh"

module fpnorm_shift
(
  input  fpnorm_pkg::mant_ext_t  mant_in,
  input  fpnorm_pkg::exp_ext_t   exp_in,
  input  logic                   sign_in,
  input  logic                   fp64,
  output fpnorm_pkg::norm_word_t norm
);

  import fpnorm_pkg::*;

  logic [`FPN_EXP_FP64+1:0] num_rs;   // Right shifts for a negative exponent
  mant_norm_t               mant_rs;
  mant_tail_t               tail_rs;
  exp_t                     exp_dec;  // Exponent for 0.1x
  logic                     msb;
  logic                     over_range;
  logic                     at_ones;

  assign msb     = mant_in[`FPN_MANT_FP64+4];
  assign num_rs  = ~exp_in + 13'd2;   // Magnitude plus one
  assign exp_dec = exp_in[`FPN_EXP_FP64-1:0] - 1'b1;

  // Shifted-out bits land in the tail
  assign {mant_rs, tail_rs} = {mant_in, {(`FPN_MANT_FP64+1){1'b0}}} >> num_rs;

  // Range checks per format
  assign over_range = fp64 ? exp_in[`FPN_EXP_FP64]
                           : |exp_in[`FPN_EXP_FP64:`FPN_EXP_FP32];
  assign at_ones    = fp64 ? &exp_in[`FPN_EXP_FP64-1:0]
                           : &exp_in[`FPN_EXP_FP32-1:0];

  always_comb
  begin
    norm      = '0;
    norm.sign = sign_in;
    if (exp_in[`FPN_EXP_FP64:0] == '0)
    begin
      norm.mant = {1'b0, mant_in[`FPN_MANT_FP64+4:5]};   // One step right
      norm.tail = {mant_in[4:0], {`FPN_MANT_FP64{1'b0}}};
      norm.uf   = |mant_in;   // Plain zero stays clean
    end
    else if (exp_in[`FPN_EXP_FP64:0] == 12'd1 && !msb)
    begin
      norm.mant = mant_in[`FPN_MANT_FP64+4:4];
      norm.tail = {mant_in[3:0], {(`FPN_MANT_FP64+1){1'b0}}};
      norm.uf   = 1'b1;
    end
    else if (exp_in[`FPN_EXP_FP64+1])   // Negative, denormal
    begin
      norm.mant = mant_rs;
      norm.tail = tail_rs;
      norm.uf   = 1'b1;
    end
    else if (over_range || (at_ones && msb))
    begin
      norm.exp = '1;   // Infinity
      norm.of  = 1'b1;
    end
    else if (msb)   // 1.x
    begin
      norm.exp  = exp_in[`FPN_EXP_FP64-1:0];
      norm.mant = mant_in[`FPN_MANT_FP64+4:4];
      norm.tail = {mant_in[3:0], {(`FPN_MANT_FP64+1){1'b0}}};
    end
    else   // 0.1x, also all-ones exponent with clear MSB
    begin
      norm.exp  = exp_dec;
      norm.mant = mant_in[`FPN_MANT_FP64+3:3];
      norm.tail = {mant_in[2:0], {(`FPN_MANT_FP64+2){1'b0}}};
    end
  end

endmodule

`default_nettype wire

//--- design/fpnorm_special.sv
////////////////////
// Special-case decoder
// Forced NaN, infinity or zero results with NV and DZ
////////////////////

`timescale 1ns/100ps
`default_nettype none

module fpnorm_special
(
  input  fpnorm_pkg::operand_class_t op_class,
  input  logic                       sign_in,
  input  logic                       op_sqrt,
  output fpnorm_pkg::special_word_t  special
);

  logic div;     // Divide when not sqrt
  logic inv_op;  // Invalid operation, NaN with nv

  assign div = ~op_sqrt;

  // Inf/Inf, sqrt(-inf), 0/0
  assign inv_op = (op_class.inf_a && ((div && op_class.inf_b) || (op_sqrt && sign_in)))
               || (op_class.zero_a && div && op_class.zero_b);

  always_comb
  begin
    special     = '0;
    special.hit = 1'b1;
    // Priority follows the divider back end
    if (op_class.nan_a || op_class.nan_b)
    begin
      special.exp_ones = 1'b1;
      special.mant_nan = 1'b1;
      special.nv       = op_class.snan;   // Quiet NaN in, no flag
    end
    else if (inv_op)
    begin
      special.exp_ones = 1'b1;
      special.mant_nan = 1'b1;
      special.nv       = 1'b1;
    end
    else if (op_class.inf_a)   // Signed infinity
    begin
      special.sign     = sign_in;
      special.exp_ones = 1'b1;
      special.of       = 1'b1;
    end
    else if (div && op_class.inf_b)
    begin
      special.sign = sign_in;   // x/inf, signed zero
      special.of   = 1'b1;
    end
    else if (op_class.zero_a)
      special.sign = sign_in;
    else if (div && op_class.zero_b)   // x/0
    begin
      special.sign     = sign_in;
      special.exp_ones = 1'b1;
      special.dz       = 1'b1;
    end
    else if (op_sqrt && sign_in)   // sqrt of negative
    begin
      special.exp_ones = 1'b1;
      special.mant_nan = 1'b1;
      special.nv       = 1'b1;
    end
    else
      special.hit = 1'b0;
  end

endmodule

`default_nettype wire

//--- design/fpnorm_pkg.sv
////////////////////
// FP normalizer types
// Width typedefs and the words passed between stages
////////////////////

`default_nettype none

`include "fpnorm_cfg.svh"

package fpnorm_pkg;

  // Hidden bit, fraction and 4 rounding bits
  typedef logic [`FPN_MANT_FP64+4:0]        mant_ext_t;
  typedef logic signed [`FPN_EXP_FP64+1:0]  exp_ext_t;    // Sign and overflow bit on top
  typedef logic [`FPN_MANT_FP64:0]          mant_norm_t;  // Includes hidden bit
  typedef logic [`FPN_MANT_FP64+4:0]        mant_tail_t;  // Bits below the mantissa
  typedef logic [`FPN_EXP_FP64-1:0]         exp_t;        // Biased result exponent
  typedef logic [2:0]                       rm_t;
  typedef logic [63:0]                      result_t;

  // Operand classes from the front end
  typedef struct packed {
    logic nan_a;
    logic nan_b;
    logic inf_a;
    logic inf_b;
    logic zero_a;
    logic zero_b;
    logic snan;   // Any signalling NaN
  } operand_class_t;

  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fflags_t;

  // Normalized value ahead of rounding
  typedef struct packed {
    logic       sign;
    exp_t       exp;
    mant_norm_t mant;
    mant_tail_t tail;   // Guard, round and sticky source
    logic       of;
    logic       uf;
  } norm_word_t;

  // Forced result for special operands
  typedef struct packed {
    logic hit;        // Overrides the rounded path
    logic sign;
    logic exp_ones;   // Exponent all ones, else zero
    logic mant_nan;   // Quiet NaN fraction, else zero
    logic nv;
    logic dz;
    logic of;
  } special_word_t;

endpackage

`default_nettype wire

//--- design/fpnorm_cfg.svh
////////////////////
// FP normalizer configuration
// Format widths, rounding-mode codes and quiet NaN fraction
////////////////////

`ifndef FPNORM_CFG_SVH
`define FPNORM_CFG_SVH

////////////////////
// Format widths

`define FPN_MANT_FP64 52   // Double fraction bits
`define FPN_MANT_FP32 23   // Single fraction bits

`define FPN_EXP_FP64 11    // Double exponent bits
`define FPN_EXP_FP32 8     // Single exponent bits

////////////////////
// Rounding modes

`define FPN_RM_NEAREST  3'd0  // Round to nearest, ties to even
`define FPN_RM_TRUNC    3'd1  // Toward zero
`define FPN_RM_PLUSINF  3'd2
`define FPN_RM_MINUSINF 3'd3

// Canonical quiet NaN, only fraction MSB set
`define FPN_MANT_NAN_FP64 52'h8_0000_0000_0000

`endif
